// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv32i_frontend
FLIST     ?= rv32i_frontend.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_rv32i_frontend.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module tb_rv32i_frontend;
    import frontend_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int IDX_W        = $clog2(MEM_WORDS);
    localparam int TEST_CYCLES  = 4000;
    localparam int STALL_CYCLES = 20;
    localparam int DRAIN_CYCLES = 100;
    // Reset and all phases plus slack
    localparam int CYCLE_LIMIT  = 2 + TEST_CYCLES + STALL_CYCLES + DRAIN_CYCLES + 100;
    localparam int ROOM_LIMIT   = `FE_BUF_DEPTH - `FE_LANES;

    logic         clk;
    logic         reset;
    word_t        inst_addr_o    [`FE_LANES];
    word_t        inst_data_i    [`FE_LANES];
    logic         redirect_i;
    word_t        redirect_pc_i;
    fetch_entry_t decode_entry_o [`FE_LANES];
    lane_mask_t   decode_valid_o;
    lane_mask_t   decode_ready_i;
    perf_count_t  perf_cycles_o;
    perf_count_t  perf_fetched_o;
    perf_count_t  perf_delivered_o;
    perf_count_t  perf_redirects_o;
    perf_count_t  perf_full_cycles_o;

    word_t        mem [MEM_WORDS];
    logic [15:0]  lfsr_q = 16'd41572;
    int           cycle_count = 0;

    // Stream and occupancy model state
    word_t        exp_pc;
    word_t        fetch_pc;
    int           occ;
    perf_count_t  cycles_tally;
    perf_count_t  delivered_tally;
    perf_count_t  redirects_tally;
    perf_count_t  full_tally;
    perf_count_t  discarded;
    perf_count_t  full_before;

    rv32i_frontend dut (
        .clk                (clk),
        .reset              (reset),
        .inst_addr_o        (inst_addr_o),
        .inst_data_i        (inst_data_i),
        .redirect_i         (redirect_i),
        .redirect_pc_i      (redirect_pc_i),
        .decode_entry_o     (decode_entry_o),
        .decode_valid_o     (decode_valid_o),
        .decode_ready_i     (decode_ready_i),
        .perf_cycles_o      (perf_cycles_o),
        .perf_fetched_o     (perf_fetched_o),
        .perf_delivered_o   (perf_delivered_o),
        .perf_redirects_o   (perf_redirects_o),
        .perf_full_cycles_o (perf_full_cycles_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // Stimulus helpers and reference model
    // ==================================================
    // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] next_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // Memory wraps on the low address bits
    function automatic word_t mem_word(word_t a);
        return mem[a[IDX_W+1:2]];
    endfunction

    always_comb begin
        for (int k = 0; k < `FE_LANES; k++) begin
            inst_data_i[k] = mem_word(inst_addr_o[k]);
        end
    end

    // Two's complement sign extension of a field of the given width
    function automatic word_t sext(word_t v, int bits);
        word_t s;
        s = word_t'(1) << (bits - 1);
        return (v ^ s) - s;
    endfunction

    function automatic word_t model_imm(word_t ins);
        case (ins[6:0])
            `FE_OP_JALR:   return sext(word_t'(ins[31:20]), 12);
            `FE_OP_STORE:  return sext(word_t'({ins[31:25], ins[11:7]}), 12);
            `FE_OP_BRANCH: return sext(word_t'({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}), 13);
            `FE_OP_LUI,
            `FE_OP_AUIPC:  return {ins[31:12], 12'h000};
            `FE_OP_JAL:    return sext(word_t'({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}), 21);
            default:       return '0;
        endcase
    endfunction

    // JAL always and branches only when backward
    function automatic logic model_taken(word_t ins);
        word_t imm;
        imm = model_imm(ins);
        return (ins[6:0] == `FE_OP_JAL) || ((ins[6:0] == `FE_OP_BRANCH) && imm[31]);
    endfunction

    // Lanes kept from a group and the fetch address that follows it
    function automatic int group_length(word_t a, output word_t next_a);
        int    n;
        logic  stop;
        word_t lane_pc;
        n      = 0;
        stop   = 1'b0;
        next_a = a + word_t'(4 * `FE_LANES);
        for (int k = 0; k < `FE_LANES; k++) begin
            lane_pc = a + word_t'(4 * k);
            if (!stop) begin
                n++;
                stop = model_taken(mem_word(lane_pc));
                if (stop) begin
                    next_a = lane_pc + model_imm(mem_word(lane_pc));
                end
            end
        end
        return n;
    endfunction

    // Valid prefix for a given occupancy
    function automatic lane_mask_t head_mask(int n);
        return (n >= 3) ? 3'b111 : (n == 2) ? 3'b011 : (n == 1) ? 3'b001 : 3'b000;
    endfunction

    task automatic fill_memory();
        word_t      w;
        logic [2:0] sel;
        for (int i = 0; i < MEM_WORDS; i++) begin
            w   = next_bits(32);
            sel = 3'(next_bits(3));
            // Roughly half the words get a predecode opcode
            case (sel)
                3'd0: w[6:0] = `FE_OP_BRANCH;
                3'd1: w[6:0] = `FE_OP_JAL;
                3'd2: w[6:0] = `FE_OP_LUI;
                3'd3: w[6:0] = `FE_OP_STORE;
                default: ;
            endcase
            // Keep control-flow targets word aligned
            if (w[6:0] == `FE_OP_BRANCH) w[8] = 1'b0;
            if (w[6:0] == `FE_OP_JAL) w[21] = 1'b0;
            mem[i] = w;
        end
    endtask

    // ==================================================
    // Checks
    // ==================================================
    task automatic stop_with_error(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) stop_with_error($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_mask(string name, lane_mask_t got, lane_mask_t exp);
        if (got !== exp) stop_with_error($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(string name, perf_count_t got, perf_count_t exp);
        if (got !== exp) stop_with_error($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) stop_with_error($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_counters();
        check_count("perf_cycles_o", perf_cycles_o, cycles_tally);
        // Every fetched entry is delivered, discarded or still buffered
        check_count("perf_fetched_o", perf_fetched_o,
                    delivered_tally + discarded + perf_count_t'(occ));
        check_count("perf_delivered_o", perf_delivered_o, delivered_tally);
        check_count("perf_redirects_o", perf_redirects_o, redirects_tally);
        check_count("perf_full_cycles_o", perf_full_cycles_o, full_tally);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_error($sformatf("Timeout, run did not end within %0d cycles", CYCLE_LIMIT));
        end
    end

    // One clock cycle entered and left on a falling edge
    task automatic run_cycle(lane_mask_t ready, logic redir, word_t new_pc);
        int           n_pop;
        int           n_push;
        logic         go;
        fetch_entry_t e;
        word_t        ins;
        word_t        next_fetch;
        check_counters();
        check_mask("decode_valid_o", decode_valid_o, head_mask(occ));
        check_word("inst_addr_o[0]", inst_addr_o[0], fetch_pc);
        check_word("inst_addr_o[1]", inst_addr_o[1], fetch_pc + 4);
        check_word("inst_addr_o[2]", inst_addr_o[2], fetch_pc + 8);
        decode_ready_i = ready;
        redirect_i     = redir;
        redirect_pc_i  = new_pc;
        n_pop  = 0;
        n_push = 0;
        go     = !redir;
        // Consumed prefix is empty while redirecting
        for (int k = 0; k < `FE_LANES; k++) begin
            go = go && decode_valid_o[k] && ready[k];
            if (go) begin
                e   = decode_entry_o[k];
                ins = mem_word(exp_pc);
                check_word("decode_entry_o.pc", e.pc, exp_pc);
                check_word("decode_entry_o.instruction", e.instruction, ins);
                check_word("decode_entry_o.imm", e.imm, model_imm(ins));
                check_flag("decode_entry_o.predicted_taken", e.predicted_taken,
                           model_taken(ins));
                exp_pc = model_taken(ins) ? exp_pc + model_imm(ins) : exp_pc + 4;
                n_pop++;
            end
        end
        // Fetch pushes and advances only with room for a whole group
        if (!redir && occ <= ROOM_LIMIT) begin
            n_push   = group_length(fetch_pc, next_fetch);
            fetch_pc = next_fetch;
        end
        if (occ > ROOM_LIMIT) full_tally++;
        if (redir) begin
            discarded += perf_count_t'(occ);
            occ      = 0;
            exp_pc   = new_pc;
            fetch_pc = new_pc;
        end else begin
            occ = occ + n_push - n_pop;
        end
        cycles_tally++;
        delivered_tally += perf_count_t'(n_pop);
        redirects_tally += perf_count_t'(redir);
        @(negedge clk);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        reset           = 1'b0;
        redirect_i      = 1'b0;
        redirect_pc_i   = '0;
        decode_ready_i  = '0;
        exp_pc          = `FE_RESET_PC;
        fetch_pc        = `FE_RESET_PC;
        occ             = 0;
        cycles_tally    = '0;
        delivered_tally = '0;
        redirects_tally = '0;
        full_tally      = '0;
        discarded       = '0;
        fill_memory();
        repeat (2) @(negedge clk);
        // State held by reset
        check_mask("decode_valid_o", decode_valid_o, '0);
        check_word("inst_addr_o[0]", inst_addr_o[0], `FE_RESET_PC);
        check_counters();
        reset = 1'b1;
        // Random ready masks with a redirect about one cycle in forty
        repeat (TEST_CYCLES) begin
            run_cycle(lane_mask_t'(next_bits(3)), next_bits(8) < 6, word_t'(next_bits(30)) << 2);
        end
        // Buffer fills while decode is stalled
        full_before = perf_full_cycles_o;
        repeat (STALL_CYCLES) run_cycle('0, 1'b0, '0);
        if (perf_full_cycles_o <= full_before) begin
            stop_with_error("Buffer never reported full while decode was stalled");
        end
        repeat (DRAIN_CYCLES) run_cycle('1, 1'b0, '0);
        check_counters();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: rv32i_frontend.f
+incdir+verilog
verilog/frontend_pkg.sv
verilog/imm_gen.sv
verilog/fetch_unit.sv
verilog/instruction_buffer.sv
verilog/perf_counters.sv
verilog/rv32i_frontend.sv
dv/tb_rv32i_frontend.sv

// File: verilog/fetch_unit.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module fetch_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       redirect_i,
    input  frontend_pkg::word_t        redirect_pc_i,
    input  logic                       space_ok_i,
    output frontend_pkg::word_t        inst_addr_o  [`FE_LANES],
    input  frontend_pkg::word_t        inst_data_i  [`FE_LANES],
    output frontend_pkg::fetch_entry_t push_entry_o [`FE_LANES],
    output frontend_pkg::lane_mask_t   push_valid_o,
    output frontend_pkg::lane_count_t  fetched_count_o
);
    import frontend_pkg::*;

    word_t      pc_q;
    word_t      next_pc;
    word_t      lane_imm    [`FE_LANES];
    word_t      lane_target [`FE_LANES];
    lane_mask_t lane_taken;
    lane_mask_t keep_mask;
    logic       accept;

    // ==================================================
    // Per-lane address and predecode
    // ==================================================
    for (genvar k = 0; k < `FE_LANES; k++) begin : g_lane
        // Sequential word addresses from the PC
        assign inst_addr_o[k] = pc_q + word_t'(4 * k);

        imm_gen u_imm_gen (
            .instr_i  (inst_data_i[k]),
            .pc_i     (inst_addr_o[k]),
            .imm_o    (lane_imm[k]),
            .taken_o  (lane_taken[k]),
            .target_o (lane_target[k])
        );

        assign push_entry_o[k] = '{
            instruction:     inst_data_i[k],
            pc:              inst_addr_o[k],
            imm:             lane_imm[k],
            predicted_taken: lane_taken[k]
        };
    end

    // ==================================================
    // Lane masking and next PC
    // ==================================================
    // Keep lanes up to the first predicted-taken one
    always_comb begin
        logic stop;
        stop      = 1'b0;
        keep_mask = '0;
        // Fall-through past the whole group
        next_pc   = pc_q + word_t'(4 * `FE_LANES);
        for (int k = 0; k < `FE_LANES; k++) begin
            if (!stop) begin
                keep_mask[k] = 1'b1;
                if (lane_taken[k]) begin
                    next_pc = lane_target[k];
                    stop    = 1'b1;
                end
            end
        end
    end

    // Group goes in only with room and no redirect
    assign accept          = space_ok_i && !redirect_i;
    assign push_valid_o    = accept ? keep_mask : '0;
    assign fetched_count_o = count_lanes(push_valid_o);

    // ==================================================
    // PC register
    // ==================================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= `FE_RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (accept) begin
            pc_q <= next_pc;
        end
        // Otherwise hold and refetch the same group
    end

endmodule

// File: verilog/frontend_pkg.sv
`include "frontend_settings.svh"

package frontend_pkg;

    // One machine word: instruction, PC or immediate
    typedef logic [`FE_XLEN-1:0] word_t;

    // One bit per fetch or decode lane
    typedef logic [`FE_LANES-1:0] lane_mask_t;

    // Number of lanes, 0 up to FE_LANES
    typedef logic [$clog2(`FE_LANES+1)-1:0] lane_count_t;

    // Predecoded instruction as stored in the buffer
    typedef struct packed {
        word_t instruction;
        word_t pc;
        word_t imm;
        logic  predicted_taken;
    } fetch_entry_t;

    // Free-running event counter
    typedef logic [31:0] perf_count_t;

    // Population count of a lane mask
    function automatic lane_count_t count_lanes(lane_mask_t mask);
        lane_count_t n;
        n = '0;
        for (int k = 0; k < `FE_LANES; k++) begin
            n = n + lane_count_t'(mask[k]);
        end
        return n;
    endfunction

endpackage

// File: verilog/frontend_settings.svh
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// Datapath width and fetch geometry
`define FE_XLEN       32
`define FE_LANES      3
`define FE_BUF_DEPTH  16

// PC out of reset
`define FE_RESET_PC   32'h0000_0000

// RV32I major opcodes that predecode looks at
`define FE_OP_BRANCH  7'b1100011
`define FE_OP_JAL     7'b1101111
`define FE_OP_JALR    7'b1100111
`define FE_OP_LUI     7'b0110111
`define FE_OP_AUIPC   7'b0010111
`define FE_OP_STORE   7'b0100011

`endif

// File: verilog/imm_gen.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module imm_gen (
    input  frontend_pkg::word_t instr_i,
    input  frontend_pkg::word_t pc_i,
    output frontend_pkg::word_t imm_o,
    output logic                taken_o,
    output frontend_pkg::word_t target_o
);

    logic [6:0] opcode;

    assign opcode = instr_i[6:0];

    // ==================================================
    // Immediate select by format
    // ==================================================
    always_comb begin
        case (opcode)
            // I-type
            `FE_OP_JALR:  imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            // S-type, split field
            `FE_OP_STORE: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            // B-type, bit 0 implied zero
            `FE_OP_BRANCH: begin
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            // U-type, upper 20 bits
            `FE_OP_LUI, `FE_OP_AUIPC: imm_o = {instr_i[31:12], 12'h000};
            // J-type
            `FE_OP_JAL: begin
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

    // Static prediction: JAL always, backward branches taken
    assign taken_o = (opcode == `FE_OP_JAL) ||
                     ((opcode == `FE_OP_BRANCH) && imm_o[31]);

    // PC-relative target
    assign target_o = pc_i + imm_o;

endmodule

// File: verilog/instruction_buffer.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module instruction_buffer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush_i,
    input  frontend_pkg::fetch_entry_t push_entry_i [`FE_LANES],
    input  frontend_pkg::lane_mask_t   push_valid_i,
    input  frontend_pkg::lane_mask_t   decode_ready_i,
    output logic                       space_ok_o,
    output logic                       full_o,
    output frontend_pkg::fetch_entry_t head_entry_o [`FE_LANES],
    output frontend_pkg::lane_mask_t   head_valid_o,
    output frontend_pkg::lane_count_t  pop_count_o
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(`FE_BUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_entry_t     mem [`FE_BUF_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    lane_mask_t       consumed;
    lane_count_t      push_count;

    // ==================================================
    // Head window, oldest entries first
    // ==================================================
    for (genvar k = 0; k < `FE_LANES; k++) begin : g_head
        // Pointer wraps on its own, depth is a power of two
        assign head_entry_o[k] = mem[rd_ptr_q + PTR_W'(k)];
        assign head_valid_o[k] = (count_q > CNT_W'(k));
    end

    // Consumed lanes form a prefix
    always_comb begin
        consumed[0] = head_valid_o[0] && decode_ready_i[0];
        for (int k = 1; k < `FE_LANES; k++) begin
            consumed[k] = consumed[k-1] && head_valid_o[k] && decode_ready_i[k];
        end
    end

    // Flush cancels both sides this cycle
    assign pop_count_o = flush_i ? '0 : count_lanes(consumed);
    assign push_count  = flush_i ? '0 : count_lanes(push_valid_i);

    // Room for one whole fetch group
    assign space_ok_o = (count_q <= CNT_W'(`FE_BUF_DEPTH - `FE_LANES));
    // Full as fetch sees it, a whole group no longer fits
    assign full_o     = !space_ok_o;

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge clk) begin
        for (int k = 0; k < `FE_LANES; k++) begin
            if (push_valid_i[k] && !flush_i) begin
                mem[wr_ptr_q + PTR_W'(k)] <= push_entry_i[k];
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Drop everything, restart empty
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop_count_o);
            wr_ptr_q <= wr_ptr_q + PTR_W'(push_count);
            count_q  <= count_q + CNT_W'(push_count) - CNT_W'(pop_count_o);
        end
    end

endmodule

// File: verilog/perf_counters.sv
`timescale 1ns/10ps

module perf_counters (
    input  logic                      clk,
    input  logic                      reset,
    input  frontend_pkg::lane_count_t fetched_i,
    input  frontend_pkg::lane_count_t delivered_i,
    input  logic                      redirect_i,
    input  logic                      full_i,
    output frontend_pkg::perf_count_t cycles_o,
    output frontend_pkg::perf_count_t fetched_o,
    output frontend_pkg::perf_count_t delivered_o,
    output frontend_pkg::perf_count_t redirects_o,
    output frontend_pkg::perf_count_t full_cycles_o
);
    import frontend_pkg::*;

    // ==================================================
    // Event accumulation
    // ==================================================
    // Each event lands on the edge closing its cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cycles_o      <= '0;
            fetched_o     <= '0;
            delivered_o   <= '0;
            redirects_o   <= '0;
            full_cycles_o <= '0;
        end else begin
            cycles_o      <= cycles_o + perf_count_t'(1);
            // Lanes pushed by fetch
            fetched_o     <= fetched_o + perf_count_t'(fetched_i);
            // Lanes taken by decode
            delivered_o   <= delivered_o + perf_count_t'(delivered_i);
            // One per redirect pulse
            redirects_o   <= redirects_o + perf_count_t'(redirect_i);
            // Stall cycles with no room
            full_cycles_o <= full_cycles_o + perf_count_t'(full_i);
        end
    end

endmodule

// File: verilog/rv32i_frontend.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module rv32i_frontend (
    input  logic                       clk,
    input  logic                       reset,
    // Instruction memory
    output frontend_pkg::word_t        inst_addr_o    [`FE_LANES],
    input  frontend_pkg::word_t        inst_data_i    [`FE_LANES],
    // Redirect from later in the pipe
    input  logic                       redirect_i,
    input  frontend_pkg::word_t        redirect_pc_i,
    // Decode side
    output frontend_pkg::fetch_entry_t decode_entry_o [`FE_LANES],
    output frontend_pkg::lane_mask_t   decode_valid_o,
    input  frontend_pkg::lane_mask_t   decode_ready_i,
    // Performance counters
    output frontend_pkg::perf_count_t  perf_cycles_o,
    output frontend_pkg::perf_count_t  perf_fetched_o,
    output frontend_pkg::perf_count_t  perf_delivered_o,
    output frontend_pkg::perf_count_t  perf_redirects_o,
    output frontend_pkg::perf_count_t  perf_full_cycles_o
);
    import frontend_pkg::*;

    fetch_entry_t push_entry [`FE_LANES];
    lane_mask_t   push_valid;
    logic         space_ok;
    logic         buf_full;
    lane_count_t  fetched_count;
    lane_count_t  pop_count;

    // ==================================================
    // Fetch and predecode
    // ==================================================
    fetch_unit u_fetch_unit (
        .clk             (clk),
        .reset           (reset),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .space_ok_i      (space_ok),
        .inst_addr_o     (inst_addr_o),
        .inst_data_i     (inst_data_i),
        .push_entry_o    (push_entry),
        .push_valid_o    (push_valid),
        .fetched_count_o (fetched_count)
    );

    // Decoupling buffer, flushed on redirect
    instruction_buffer u_instruction_buffer (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (redirect_i),
        .push_entry_i   (push_entry),
        .push_valid_i   (push_valid),
        .decode_ready_i (decode_ready_i),
        .space_ok_o     (space_ok),
        .full_o         (buf_full),
        .head_entry_o   (decode_entry_o),
        .head_valid_o   (decode_valid_o),
        .pop_count_o    (pop_count)
    );

    // ==================================================
    // Counters
    // ==================================================
    perf_counters u_perf_counters (
        .clk           (clk),
        .reset         (reset),
        .fetched_i     (fetched_count),
        .delivered_i   (pop_count),
        .redirect_i    (redirect_i),
        .full_i        (buf_full),
        .cycles_o      (perf_cycles_o),
        .fetched_o     (perf_fetched_o),
        .delivered_o   (perf_delivered_o),
        .redirects_o   (perf_redirects_o),
        .full_cycles_o (perf_full_cycles_o)
    );

endmodule
